// ==== build.f ====
+incdir+logic
logic/pif_data_pkg.sv
logic/pif_ctrl_pkg.sv
logic/pif_wr_sequencer.sv
logic/pif_frame_regs.sv
logic/pif_rd_serializer.sv
logic/pif_top.sv
dv/pif_assert.sv
dv/pif_checker.sv
dv/pif_tb.sv

// ==== Bender.yml ====
package:
  name: pif

sources:
  - include_dirs:
      - logic
    files:
      - logic/pif_data_pkg.sv
      - logic/pif_ctrl_pkg.sv
      - logic/pif_wr_sequencer.sv
      - logic/pif_frame_regs.sv
      - logic/pif_rd_serializer.sv
      - logic/pif_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - dv/pif_assert.sv
      - dv/pif_checker.sv
      - dv/pif_tb.sv

// ==== dv/pif_tb.sv ====
/*
 * Testbench for pif_top
 * Clock, reset, read FIFO model, stimulus table, LFSR data and watchdog
 */
`default_nettype none

`include "pif_defines.svh"

module pif_tb;

  localparam int CLK_P = 4;
  localparam int NROWS = 9;
  localparam pif_data_pkg::pif_addr_t LONG = 1 << `PIF_LONG_BIT;

  typedef enum logic [2:0] {K_SHORT, K_LONG, K_BURST, K_READ, K_OFF} kind_t;
  typedef struct packed {
    kind_t                   kind;
    pif_data_pkg::pif_addr_t addr;
    logic [3:0]              cnt;   // Burst words or queued read words
  } row_t;

  logic                         fcb_sys_clk;
  logic                         fcb_sys_rst_n;
  logic                         fcb_sys_stm;
  logic                         fcb_pif_en;
  pif_data_pkg::pif_in_t        pif_in;
  logic                         frwf_crf_empty;
  pif_data_pkg::pif_word_t      frwf_crf_rd_data;
  pif_data_pkg::pif_out_t       pif_out;
  logic                         fpif_frwf_pif_on;
  logic                         fpif_frwf_wff_wr_en;
  pif_data_pkg::pif_wff_entry_t fpif_frwf_wff_wr_data;
  logic                         fpif_frwf_crf_rd_en;
  int                           err_cnt;
  int                           wr_cnt;
  int                           rd_cnt;
  logic [15:0]                  lfsr_q;
  row_t                         rows [NROWS];
  pif_data_pkg::pif_word_t      rdq [$];  // Read FIFO model, head first

  pif_top dut (.*);

  pif_checker chk (.*);

  initial begin
    fcb_sys_clk = 1'b0;
    forever #(CLK_P / 2) fcb_sys_clk = ~fcb_sys_clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_byte(output pif_data_pkg::pif_byte_t b);
    for (int i = 0; i < `PIF_BYTE_W; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      b[i]   = lfsr_q[0];  // One step per bit
    end
  endtask

  function automatic int row_bytes(input row_t r);
    case (r.kind)
      K_SHORT: return 1;
      K_LONG:  return 1 + `PIF_WORD_BYTES;
      K_BURST: return 1 + `PIF_WORD_BYTES * r.cnt;
      K_READ:  return `PIF_WORD_BYTES * r.cnt;
      default: return 4;
    endcase
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge fcb_sys_clk);
      #1;
    end
  endtask

  task automatic put_byte(input pif_data_pkg::pif_byte_t b, input int gap);
    pif_in = {1'b1, b};
    idle(1);
    pif_in.vldi = 1'b0;
    idle(gap);  // Wait states
  endtask

  task automatic send_word(input int gap, input int last_gap);
    pif_data_pkg::pif_byte_t b;
    for (int i = 0; i < `PIF_WORD_BYTES; i++) begin
      rand_byte(b);
      put_byte(b, (i == `PIF_WORD_BYTES - 1) ? last_gap : gap);
    end
  endtask

  task automatic read_words(input int n);
    pif_data_pkg::pif_byte_t b;
    pif_data_pkg::pif_word_t w;
    logic                    take;
    repeat (n) begin
      for (int i = 0; i < `PIF_WORD_BYTES; i++) begin
        rand_byte(b);
        w[i*`PIF_BYTE_W +: `PIF_BYTE_W] = b;
      end
      rdq.push_back(w);
    end
    while (rdq.size() > 0) begin
      frwf_crf_empty   = 1'b0;
      frwf_crf_rd_data = rdq[0];  // First word fall through
      @(posedge fcb_sys_clk);
      take = fpif_frwf_crf_rd_en;
      #1;
      if (take) w = rdq.pop_front();
    end
    frwf_crf_empty   = 1'b1;
    frwf_crf_rd_data = '0;
  endtask

  task automatic abort_long(input pif_data_pkg::pif_addr_t addr);
    pif_data_pkg::pif_byte_t b;
    put_byte(addr | LONG, 0);
    repeat (2) begin
      rand_byte(b);
      put_byte(b, 0);
    end
    fcb_pif_en = 1'b0;  // Drop enable in the middle of a word
    put_byte(addr & ~LONG, 1);  // Ignored while off
    fcb_pif_en = 1'b1;
    idle(1);  // Back to WR_ADDR
  endtask

  initial begin : main
    int exp_wr;
    int exp_rd;
    int total;
    exp_wr           = 0;
    exp_rd           = 0;
    fcb_sys_rst_n    = 1'b0;
    fcb_sys_stm      = 1'b0;
    fcb_pif_en       = 1'b0;
    pif_in           = '0;
    frwf_crf_empty   = 1'b1;
    frwf_crf_rd_data = '0;
    lfsr_q           = 16'd63;
    rows = '{
      '{K_SHORT, 8'h12, 4'd0},
      '{K_LONG,  8'h85, 4'd0},
      '{K_BURST, 8'h9F, 4'd3},  // Runs into A0 and holds there
      '{K_BURST, 8'hA0, 4'd2},
      '{K_READ,  8'h00, 4'd1},
      '{K_OFF,   8'h88, 4'd0},
      '{K_LONG,  8'hC3, 4'd0},
      '{K_READ,  8'h00, 4'd3},
      '{K_SHORT, 8'h7F, 4'd0}
    };
    repeat (4) @(posedge fcb_sys_clk);
    #1;
    fcb_sys_rst_n = 1'b1;
    fcb_pif_en    = 1'b1;
    put_byte(8'h83, 1);  // No test mode yet
    put_byte(8'h05, 1);  // Would be a short write if accepted
    fcb_sys_stm = 1'b1;
    idle(1);
    foreach (rows[i]) begin
      case (rows[i].kind)
        K_SHORT: begin
          put_byte(rows[i].addr & ~LONG, 1);
          exp_wr++;
        end
        K_LONG: begin
          put_byte(rows[i].addr | LONG, 2);
          send_word(2, 1);  // Gaps between data bytes
          exp_wr++;
        end
        K_BURST: begin
          put_byte(rows[i].addr | LONG, 0);
          repeat (rows[i].cnt - 1) send_word(0, 0);
          send_word(0, 1);  // Gap ends the burst
          exp_wr += rows[i].cnt;
        end
        K_READ: begin
          read_words(rows[i].cnt);
          exp_rd += rows[i].cnt;
        end
        default: abort_long(rows[i].addr);
      endcase
    end
    idle(4);
    total = err_cnt + dut.u_assert.fail_cnt;
    if (wr_cnt != exp_wr) begin
      total++;
      $display("wrong number of write FIFO entries, expected %0d, saw %0d", exp_wr, wr_cnt);
    end
    if (rd_cnt != exp_rd) begin
      total++;
      $display("wrong number of read words, expected %0d, saw %0d", exp_rd, rd_cnt);
    end
    $display("writes %0d, read words %0d, assertion failures %0d, errors %0d",
             wr_cnt, rd_cnt, dut.u_assert.fail_cnt, total);
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    #1;
    limit = 64;  // Reset, enable steps and drain margin
    foreach (rows[i]) limit += 8 * row_bytes(rows[i]);
    #(limit * CLK_P);
    $display("timeout, the test table did not finish within %0d cycles", limit);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/pif_checker.sv ====
/*
 * Scoreboard for pif_top
 * Reference model of write FIFO entries and read beats, error counting
 */
`default_nettype none

`include "pif_defines.svh"

module pif_checker (
  input  logic                         fcb_sys_clk,
  input  logic                         fcb_sys_rst_n,
  input  logic                         fcb_sys_stm,
  input  logic                         fcb_pif_en,
  input  pif_data_pkg::pif_in_t        pif_in,
  input  logic                         frwf_crf_empty,
  input  pif_data_pkg::pif_word_t      frwf_crf_rd_data,
  input  pif_data_pkg::pif_out_t       pif_out,
  input  logic                         fpif_frwf_pif_on,
  input  logic                         fpif_frwf_wff_wr_en,
  input  pif_data_pkg::pif_wff_entry_t fpif_frwf_wff_wr_data,
  input  logic                         fpif_frwf_crf_rd_en,
  output int                           err_cnt,
  output int                           wr_cnt,
  output int                           rd_cnt   // Read words completed
);

  int                      wph;     // 0 idle, 1 addr, 2 short, 3 data, 4 next
  int                      rph;     // 0 idle, 1 wait word, 2..4 later beats
  int                      nb;      // Data bytes taken in this word
  int                      bi;      // Lane of the current beat
  logic [1:0]              exp_wr;  // Bit 0 push due, bit 1 data known
  logic                    exp_vld;
  pif_data_pkg::pif_addr_t a;
  pif_data_pkg::pif_word_t d;       // Bytes as the host sent them
  pif_data_pkg::pif_word_t rw;      // Word under serialization

  initial begin
    err_cnt = 0;
    wr_cnt  = 0;
    rd_cnt  = 0;
  end

  task automatic cmp(input string name, input logic [39:0] exp, input logic [39:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("error %0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  always @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      wph = 0;
      rph = 0;
      if (fpif_frwf_wff_wr_en === 1'b1 || fpif_frwf_crf_rd_en === 1'b1
          || pif_out.vldo === 1'b1 || fpif_frwf_pif_on === 1'b1) begin
        err_cnt++;
        $display("output active during reset at %0t", $time);
      end
    end else begin
      exp_wr  = 2'b00;
      exp_vld = 1'b0;
      bi      = rph - 1;
      cmp("fpif_frwf_pif_on", fcb_sys_stm & fcb_pif_en, fpif_frwf_pif_on);
      if (!(fcb_sys_stm & fcb_pif_en)) begin
        wph = 0;  // Off drops any command
        rph = 0;
      end else begin
        case (wph)
          0: wph = 1;
          1: if (pif_in.vldi) begin
            a   = pif_in.di;
            nb  = 0;
            wph = pif_in.di[`PIF_LONG_BIT] ? 3 : 2;
          end
          2: begin
            exp_wr = 2'b01;  // Short entry, data free
            wph    = 1;
          end
          3: if (pif_in.vldi) begin
            d[nb*`PIF_BYTE_W +: `PIF_BYTE_W] = pif_in.di;  // First byte lowest
            nb++;
            if (nb == `PIF_WORD_BYTES) begin
              exp_wr = 2'b11;
              wph    = 4;
            end
          end
          default: if (pif_in.vldi) begin
            d[`PIF_BYTE_W-1:0] = pif_in.di;  // Burst word starts at once
            nb                 = 1;
            if (a != `PIF_HOLD_ADDR) a++;
            wph                = 3;
          end else begin
            wph = 1;
          end
        endcase
        if (rph == 0) begin
          rph = 1;
        end else if (rph == 1 && !frwf_crf_empty) begin
          rw      = frwf_crf_rd_data;  // Head word shown with beat 0
          exp_vld = 1'b1;
          rph     = 2;
        end else if (rph > 1) begin
          exp_vld = 1'b1;
          rph     = (rph == `PIF_WORD_BYTES) ? 1 : rph + 1;
        end
      end
      if (exp_wr[0] != fpif_frwf_wff_wr_en) begin
        err_cnt++;
        $display("%s at %0t", exp_wr[0] ? "missing write FIFO entry"
                                        : "unexpected write FIFO push", $time);
      end else if (exp_wr[0]) begin
        wr_cnt++;
        cmp("fpif_frwf_wff_wr_data.addr", a, fpif_frwf_wff_wr_data.addr);
        if (exp_wr[1]) cmp("fpif_frwf_wff_wr_data.data", d, fpif_frwf_wff_wr_data.data);
      end
      if (exp_vld != pif_out.vldo) begin
        err_cnt++;
        $display("%s at %0t", exp_vld ? "missing read beat" : "unexpected read beat", $time);
      end else if (exp_vld) begin
        cmp("pif_out.dout", rw[bi*`PIF_BYTE_W +: `PIF_BYTE_W], pif_out.dout);
        cmp("fpif_frwf_crf_rd_en", bi == `PIF_WORD_BYTES - 1, fpif_frwf_crf_rd_en);
        if (bi == `PIF_WORD_BYTES - 1) rd_cnt++;
      end else begin
        cmp("fpif_frwf_crf_rd_en", 1'b0, fpif_frwf_crf_rd_en);
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/pif_assert.sv ====
/*
 * Concurrent assertions on the parallel configuration interface top level
 * Attached to pif_top by bind
 */
`default_nettype none

module pif_assert (
  input logic fcb_sys_clk,
  input logic fcb_sys_rst_n,
  input logic pif_on,
  input logic wr_en,
  input logic rd_en,
  input logic vldo
);

  int fail_cnt = 0;  // Read by the testbench at the end

  // Pop only with a visible beat
  a_rd_with_beat: assert property (@(posedge fcb_sys_clk) disable iff (!fcb_sys_rst_n)
    rd_en |-> vldo)
    else begin
      $error("rd_en high without vldo");
      fail_cnt++;
    end

  a_quiet_when_off: assert property (@(posedge fcb_sys_clk) disable iff (!fcb_sys_rst_n)
    !pif_on |-> !wr_en && !vldo)
    else begin
      $error("write or read activity while interface off");
      fail_cnt++;
    end

  // Whole words only, four beats each
  a_beat_run: assert property (@(posedge fcb_sys_clk) disable iff (!fcb_sys_rst_n)
    $rose(vldo) |-> vldo [*4])
    else begin
      $error("vldo run shorter than four beats");
      fail_cnt++;
    end

  a_run_end: assert property (@(posedge fcb_sys_clk) disable iff (!fcb_sys_rst_n)
    $fell(vldo) |-> $past(rd_en))
    else begin
      $error("vldo run ended without a pop");
      fail_cnt++;
    end

endmodule

bind pif_top pif_assert u_assert (
  .fcb_sys_clk  (fcb_sys_clk),
  .fcb_sys_rst_n(fcb_sys_rst_n),
  .pif_on       (fpif_frwf_pif_on),
  .wr_en        (fpif_frwf_wff_wr_en),
  .rd_en        (fpif_frwf_crf_rd_en),
  .vldo         (pif_out.vldo)
);

`default_nettype wire

// ==== logic/pif_top.sv ====
/*
 * Parallel configuration interface top level
 * Enable decode, write sequencer, frame registers and read serializer
 */
`default_nettype none

module pif_top (
  input  logic                         fcb_sys_clk,
  input  logic                         fcb_sys_rst_n,
  input  logic                         fcb_sys_stm,       // Test mode
  input  logic                         fcb_pif_en,        // Interface enable
  input  pif_data_pkg::pif_in_t        pif_in,
  input  logic                         frwf_crf_empty,
  input  pif_data_pkg::pif_word_t      frwf_crf_rd_data,
  output pif_data_pkg::pif_out_t       pif_out,
  output logic                         fpif_frwf_pif_on,
  output logic                         fpif_frwf_wff_wr_en,
  output pif_data_pkg::pif_wff_entry_t fpif_frwf_wff_wr_data,
  output logic                         fpif_frwf_crf_rd_en
);

  logic                       pif_on;
  pif_ctrl_pkg::pif_reg_ctl_t reg_ctl;
  pif_data_pkg::pif_addr_t    cur_addr;

  // Only place the enable condition is decoded
  assign pif_on           = fcb_sys_stm & fcb_pif_en;
  assign fpif_frwf_pif_on = pif_on;

  pif_wr_sequencer u_wr_seq (
    .fcb_sys_clk  (fcb_sys_clk),
    .fcb_sys_rst_n(fcb_sys_rst_n),
    .pif_on       (pif_on),
    .pif_in       (pif_in),
    .cur_addr     (cur_addr),
    .reg_ctl      (reg_ctl),
    .wr_en        (fpif_frwf_wff_wr_en)
  );

  pif_frame_regs u_frame_regs (
    .fcb_sys_clk  (fcb_sys_clk),
    .fcb_sys_rst_n(fcb_sys_rst_n),
    .pif_on       (pif_on),
    .pif_in       (pif_in),
    .reg_ctl      (reg_ctl),
    .cur_addr     (cur_addr),
    .entry        (fpif_frwf_wff_wr_data)
  );

  pif_rd_serializer u_rd_ser (
    .fcb_sys_clk  (fcb_sys_clk),
    .fcb_sys_rst_n(fcb_sys_rst_n),
    .pif_on       (pif_on),
    .crf_empty    (frwf_crf_empty),
    .crf_data     (frwf_crf_rd_data),
    .pif_out      (pif_out),
    .rd_en        (fpif_frwf_crf_rd_en)
  );

endmodule

`default_nettype wire

// ==== logic/pif_rd_serializer.sv ====
/*
 * Read serializer
 * Splits config read FIFO words into four byte beats, pops on the last
 */
`default_nettype none

`include "pif_defines.svh"

module pif_rd_serializer (
  input  logic                    fcb_sys_clk,
  input  logic                    fcb_sys_rst_n,
  input  logic                    pif_on,
  input  logic                    crf_empty,  // Read FIFO empty flag
  input  pif_data_pkg::pif_word_t crf_data,   // Head word, first-word-fall-through
  output pif_data_pkg::pif_out_t  pif_out,
  output logic                    rd_en       // Pop with byte 3
);

  pif_ctrl_pkg::pif_rd_state_t           state_q;
  pif_ctrl_pkg::pif_rd_state_t           state_d;
  logic [$clog2(`PIF_WORD_BYTES)-1:0]    byte_sel;  // Lane shown on dout

  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      state_q <= pif_ctrl_pkg::RD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d      = state_q;
    byte_sel     = '0;
    pif_out.vldo = 1'b0;
    rd_en        = 1'b0;

    if (!pif_on) begin
      state_d = pif_ctrl_pkg::RD_IDLE;
    end else begin
      unique case (state_q)
        pif_ctrl_pkg::RD_IDLE: state_d = pif_ctrl_pkg::RD_B0;
        pif_ctrl_pkg::RD_B0: begin
          if (!crf_empty) begin  // Start beat same cycle
            pif_out.vldo = 1'b1;
            state_d      = pif_ctrl_pkg::RD_B1;
          end
        end
        pif_ctrl_pkg::RD_B1: begin
          pif_out.vldo = 1'b1;
          byte_sel     = 2'd1;
          state_d      = pif_ctrl_pkg::RD_B2;
        end
        pif_ctrl_pkg::RD_B2: begin
          pif_out.vldo = 1'b1;
          byte_sel     = 2'd2;
          state_d      = pif_ctrl_pkg::RD_B3;
        end
        pif_ctrl_pkg::RD_B3: begin
          pif_out.vldo = 1'b1;
          byte_sel     = 2'd3;
          rd_en        = 1'b1;  // Word fully sent
          state_d      = pif_ctrl_pkg::RD_B0;
        end
        default: state_d = pif_ctrl_pkg::RD_IDLE;
      endcase
    end
  end

  // Byte mux, lane 0 first
  assign pif_out.dout = crf_data[byte_sel*`PIF_BYTE_W +: `PIF_BYTE_W];

endmodule

`default_nettype wire

// ==== logic/pif_frame_regs.sv ====
/*
 * Frame register bank
 * Address counter, data bytes 0 to 2 and write FIFO entry assembly
 */
`default_nettype none

`include "pif_defines.svh"

module pif_frame_regs (
  input  logic                         fcb_sys_clk,
  input  logic                         fcb_sys_rst_n,
  input  logic                         pif_on,
  input  pif_data_pkg::pif_in_t        pif_in,
  input  pif_ctrl_pkg::pif_reg_ctl_t   reg_ctl,
  output pif_data_pkg::pif_addr_t      cur_addr,  // To sequencer for hold compare
  output pif_data_pkg::pif_wff_entry_t entry
);

  pif_data_pkg::pif_addr_t                          addr_q;
  pif_data_pkg::pif_byte_t [`PIF_WORD_BYTES-2:0]    byte_q;  // Bytes 0..2 only

  // Address register
  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      addr_q <= '0;
    end else if (pif_on) begin
      if (reg_ctl.addr_inc) begin
        addr_q <= addr_q + 1'b1;  // Burst step
      end else if (reg_ctl.addr_we) begin
        addr_q <= pif_in.di;
      end
    end
  end

  // Data byte registers, one strobe each
  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      byte_q <= '0;
    end else if (pif_on) begin
      for (int i = 0; i < `PIF_WORD_BYTES - 1; i++) begin
        if (reg_ctl.byte_we[i]) begin
          byte_q[i] <= pif_in.di;
        end
      end
    end
  end

  assign cur_addr = addr_q;

  // Entry, byte 3 live from the host lane
  always_comb begin
    entry.addr = addr_q;
    entry.data = {pif_in.di, byte_q};  // First byte in lowest lane
  end

endmodule

`default_nettype wire

// ==== logic/pif_wr_sequencer.sv ====
/*
 * Write command FSM
 * Decodes short, long and burst commands, drives register strobes and wr_en
 */
`default_nettype none

`include "pif_defines.svh"

module pif_wr_sequencer (
  input  logic                       fcb_sys_clk,
  input  logic                       fcb_sys_rst_n,
  input  logic                       pif_on,    // Test mode and enable
  input  pif_data_pkg::pif_in_t      pif_in,
  input  pif_data_pkg::pif_addr_t    cur_addr,  // Registered address
  output pif_ctrl_pkg::pif_reg_ctl_t reg_ctl,
  output logic                       wr_en      // Write FIFO push
);

  pif_ctrl_pkg::pif_wr_state_t state_q;
  pif_ctrl_pkg::pif_wr_state_t state_d;

  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      state_q <= pif_ctrl_pkg::WR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;  // Hold by default, covers the wait states
    reg_ctl = '0;
    wr_en   = 1'b0;

    if (!pif_on) begin
      state_d = pif_ctrl_pkg::WR_IDLE;  // Interface off, abandon any command
    end else begin
      unique case (state_q)
        pif_ctrl_pkg::WR_IDLE: begin
          state_d = pif_ctrl_pkg::WR_ADDR;
        end
        pif_ctrl_pkg::WR_ADDR: begin
          if (pif_in.vldi) begin
            reg_ctl.addr_we = 1'b1;
            // Command kind from the live address byte
            if (pif_in.di[`PIF_LONG_BIT]) begin
              state_d = pif_ctrl_pkg::WR_B0;
            end else begin
              state_d = pif_ctrl_pkg::WR_SHORT;
            end
          end
        end
        pif_ctrl_pkg::WR_SHORT: begin
          wr_en   = 1'b1;  // Address only, data field don't care
          state_d = pif_ctrl_pkg::WR_ADDR;
        end
        pif_ctrl_pkg::WR_B0: begin
          if (pif_in.vldi) begin
            reg_ctl.byte_we[0] = 1'b1;
            state_d            = pif_ctrl_pkg::WR_B1;
          end
        end
        pif_ctrl_pkg::WR_B1: begin
          if (pif_in.vldi) begin
            reg_ctl.byte_we[1] = 1'b1;
            state_d            = pif_ctrl_pkg::WR_B2;
          end
        end
        pif_ctrl_pkg::WR_B2: begin
          if (pif_in.vldi) begin
            reg_ctl.byte_we[2] = 1'b1;
            state_d            = pif_ctrl_pkg::WR_B3;
          end
        end
        pif_ctrl_pkg::WR_B3: begin
          // Byte 3 goes straight into the entry
          if (pif_in.vldi) begin
            wr_en   = 1'b1;
            state_d = pif_ctrl_pkg::WR_NEXT;
          end
        end
        pif_ctrl_pkg::WR_NEXT: begin
          if (pif_in.vldi) begin
            // Next burst word, first byte already here
            reg_ctl.byte_we[0] = 1'b1;
            reg_ctl.addr_inc   = (cur_addr != `PIF_HOLD_ADDR);  // A0 stays put
            state_d            = pif_ctrl_pkg::WR_B1;
          end else begin
            state_d = pif_ctrl_pkg::WR_ADDR;  // Gap ends the burst
          end
        end
        default: begin
          state_d = pif_ctrl_pkg::WR_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/pif_ctrl_pkg.sv ====
/*
 * Control types for the parallel configuration interface
 * Write and read FSM state encodings, register strobe struct
 */
`default_nettype none

`include "pif_defines.svh"

package pif_ctrl_pkg;

  // Write command FSM
  typedef enum logic [2:0] {
    WR_IDLE, WR_ADDR, WR_SHORT, WR_B0, WR_B1, WR_B2, WR_B3, WR_NEXT
  } pif_wr_state_t;

  // Read serializer FSM
  typedef enum logic [2:0] {
    RD_IDLE, RD_B0, RD_B1, RD_B2, RD_B3
  } pif_rd_state_t;

  // Strobes from sequencer to frame registers
  typedef struct packed {
    logic                       addr_we;   // Load address from di
    logic                       addr_inc;  // Burst address step
    logic [`PIF_WORD_BYTES-1:0] byte_we;   // Per data byte load, byte 3 unused
  } pif_reg_ctl_t;

endpackage

`default_nettype wire

// ==== logic/pif_data_pkg.sv ====
/*
 * Data format types for the parallel configuration interface
 * Byte, word, address, write FIFO entry and host port structs
 */
`default_nettype none

`include "pif_defines.svh"

package pif_data_pkg;

  typedef logic [`PIF_BYTE_W-1:0]                 pif_byte_t;  // One host byte
  typedef logic [`PIF_BYTE_W*`PIF_WORD_BYTES-1:0] pif_word_t;  // Config data word
  typedef logic [`PIF_ADDR_W-1:0]                 pif_addr_t;  // Register address

  // Write FIFO entry, address on top of data
  typedef struct packed {
    pif_addr_t addr;
    pif_word_t data;
  } pif_wff_entry_t;

  // Host to block
  typedef struct packed {
    logic      vldi;  // Byte strobe
    pif_byte_t di;
  } pif_in_t;

  // Block to host
  typedef struct packed {
    logic      vldo;  // Read beat strobe
    pif_byte_t dout;
  } pif_out_t;

endpackage

`default_nettype wire

// ==== logic/pif_defines.svh ====
/*
 * Shared width and encoding macros for the byte-wide parallel configuration interface
 */
`ifndef PIF_DEFINES_SVH
`define PIF_DEFINES_SVH

// Host byte lane width
`define PIF_BYTE_W     8

// Bytes per configuration data word
`define PIF_WORD_BYTES 4

// Register address field of a write FIFO entry
`define PIF_ADDR_W     8

// Burst address that never increments
`define PIF_HOLD_ADDR  8'hA0

// Address bit selecting a long command
`define PIF_LONG_BIT   7

`endif
